// File: kotku_pkg.sv
/*
 * Kotku CPU bus core shared definitions
 * Wishbone request/response types, slave identifiers and the
 * address window map used to steer 8086 bus cycles to the slave ports
 */
`default_nettype none

package kotku_pkg;

  typedef logic [19:1] addr_t;  // CPU word address
  typedef logic [15:0] data_t;

  // Slave port identifiers, also the s_cyc_o bit index
  typedef enum logic [2:0] {
    SLV_ROM   = 3'd0,
    SLV_VGA   = 3'd1,
    SLV_RAM   = 3'd2,
    SLV_UART  = 3'd3,
    SLV_KEYB  = 3'd4,
    SLV_TIMER = 3'd5,
    SLV_GPIO  = 3'd6,
    SLV_NONE  = 3'd7   // Unmapped, acked by the core
  } slave_e;

  localparam int NUM_SLAVES = 7;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        tga;  // I/O space
    logic        we;
    logic [1:0]  sel;  // Byte lanes
    addr_t       adr;
    data_t       dat;  // Write data
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    data_t dat;  // Read data
  } wb_rsp_t;

  // Memory windows, compared on adr[19:1]
  localparam addr_t MEM_ROM_BASE   = 19'h7ff00;  // 0xffe00 - 0xfffff
  localparam addr_t MEM_ROM_MASK   = 19'h7ff00;
  localparam addr_t MEM_VGA_BASE   = 19'h50000;  // 0xa0000 - 0xbffff
  localparam addr_t MEM_VGA_MASK   = 19'h70000;

  // I/O windows, upper four address bits ignored
  localparam addr_t IO_VGA_BASE    = 19'h001e0;  // 0x3c0 - 0x3df
  localparam addr_t IO_VGA_MASK    = 19'h07ff0;
  localparam addr_t IO_UART_BASE   = 19'h001fc;  // 0x3f8 - 0x3ff
  localparam addr_t IO_UART_MASK   = 19'h07ffc;
  localparam addr_t IO_KEYB_BASE   = 19'h00030;  // 0x60 and 0x64
  localparam addr_t IO_KEYB_MASK   = 19'h07ffd;  // Bit 2 is don't care
  localparam addr_t IO_TIMER_BASE  = 19'h00020;  // 0x40 - 0x43
  localparam addr_t IO_TIMER_MASK  = 19'h07ffe;
  localparam addr_t IO_GPIO_BASE   = 19'h07880;  // 0xf100 - 0xf103
  localparam addr_t IO_GPIO_MASK   = 19'h07ffe;

  // Address falls inside a base/mask window
  function automatic logic win_hit(input addr_t adr, input addr_t base,
                                   input addr_t mask);
    return (adr & mask) == base;
  endfunction

  // Width of an interrupt identifier for n lines
  function automatic int iid_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

// File: mem_decoder.sv
/*
 * Memory space decoder
 * Maps a CPU word address to the boot ROM, the VGA frame window,
 * or the RAM that covers the rest of the 1 MB space
 */
`timescale 1ns/1ps
`default_nettype none

module mem_decoder (
  input  wire kotku_pkg::addr_t  adr_i,
  output kotku_pkg::slave_e      slave_o
);

  logic rom_hit;
  logic vga_hit;

  assign rom_hit = kotku_pkg::win_hit(adr_i, kotku_pkg::MEM_ROM_BASE,
                                      kotku_pkg::MEM_ROM_MASK);
  assign vga_hit = kotku_pkg::win_hit(adr_i, kotku_pkg::MEM_VGA_BASE,
                                      kotku_pkg::MEM_VGA_MASK);

  // ROM first, RAM catches everything else
  always_comb begin
    if (rom_hit) begin
      slave_o = kotku_pkg::SLV_ROM;
    end else if (vga_hit) begin
      slave_o = kotku_pkg::SLV_VGA;
    end else begin
      slave_o = kotku_pkg::SLV_RAM;
    end
  end

endmodule

`default_nettype wire

// File: io_decoder.sv
/*
 * I/O space decoder
 * Maps a port address to the VGA, UART, keyboard, timer or GPIO
 * port, or reports a miss for the bus merge to acknowledge
 */
`timescale 1ns/1ps
`default_nettype none

module io_decoder (
  input  wire kotku_pkg::addr_t  adr_i,
  output kotku_pkg::slave_e      slave_o
);

  logic vga_hit;
  logic uart_hit;
  logic keyb_hit;
  logic timer_hit;
  logic gpio_hit;

  assign vga_hit   = kotku_pkg::win_hit(adr_i, kotku_pkg::IO_VGA_BASE,
                                        kotku_pkg::IO_VGA_MASK);
  assign uart_hit  = kotku_pkg::win_hit(adr_i, kotku_pkg::IO_UART_BASE,
                                        kotku_pkg::IO_UART_MASK);
  assign keyb_hit  = kotku_pkg::win_hit(adr_i, kotku_pkg::IO_KEYB_BASE,
                                        kotku_pkg::IO_KEYB_MASK);
  assign timer_hit = kotku_pkg::win_hit(adr_i, kotku_pkg::IO_TIMER_BASE,
                                        kotku_pkg::IO_TIMER_MASK);
  assign gpio_hit  = kotku_pkg::win_hit(adr_i, kotku_pkg::IO_GPIO_BASE,
                                        kotku_pkg::IO_GPIO_MASK);

  always_comb begin
    if (vga_hit) begin
      slave_o = kotku_pkg::SLV_VGA;
    end else if (uart_hit) begin
      slave_o = kotku_pkg::SLV_UART;
    end else if (keyb_hit) begin
      slave_o = kotku_pkg::SLV_KEYB;
    end else if (timer_hit) begin
      slave_o = kotku_pkg::SLV_TIMER;
    end else if (gpio_hit) begin
      slave_o = kotku_pkg::SLV_GPIO;
    end else begin
      slave_o = kotku_pkg::SLV_NONE;  // Default ack in the merge
    end
  end

endmodule

`default_nettype wire

// File: cpu_bus_merge.sv
/*
 * CPU bus merge
 * Picks the memory or I/O decoder result by tga, gates cyc to one
 * slave port and returns its ack and read data to the master.
 * Unmapped I/O is acked here with zero data, and interrupt and NMI
 * vectors replace the read data during acknowledge cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_merge #(
  parameter kotku_pkg::data_t NMI_VECTOR = 16'd2,
  parameter kotku_pkg::data_t IRQ_BASE   = 16'd8,
  parameter int               NUM_IRQ    = 8,
  localparam int              IID_W      = kotku_pkg::iid_width(NUM_IRQ)
) (
  // Master side
  input  wire kotku_pkg::wb_req_t  m_req_i,
  output logic                     m_ack_o,
  output kotku_pkg::data_t         m_dat_o,

  // Decoder results
  input  wire kotku_pkg::slave_e   mem_slave_i,
  input  wire kotku_pkg::slave_e   io_slave_i,

  // Slave side
  output kotku_pkg::wb_req_t                  s_req_o,
  output logic [kotku_pkg::NUM_SLAVES-1:0]    s_cyc_o,
  input  wire kotku_pkg::wb_rsp_t             s_rsp_i [kotku_pkg::NUM_SLAVES],

  // Interrupt acknowledge
  input  wire [IID_W-1:0]          iid_i,
  input  wire                      inta_i,
  input  wire                      nmia_i
);

  kotku_pkg::slave_e sel_slave;
  kotku_pkg::data_t  bus_dat;
  logic              req_act;

  assign sel_slave = m_req_i.tga ? io_slave_i : mem_slave_i;
  assign req_act   = m_req_i.cyc & m_req_i.stb;

  // Request is broadcast, only cyc is steered
  assign s_req_o = m_req_i;

  always_comb begin
    s_cyc_o = '0;
    if (sel_slave != kotku_pkg::SLV_NONE) begin
      s_cyc_o[int'(sel_slave)] = m_req_i.cyc;
    end
  end

  // Response from the chosen port
  always_comb begin
    if (sel_slave == kotku_pkg::SLV_NONE) begin
      m_ack_o = req_act;  // Same cycle ack for a miss
      bus_dat = '0;
    end else begin
      m_ack_o = req_act & s_rsp_i[int'(sel_slave)].ack;
      bus_dat = s_rsp_i[int'(sel_slave)].dat;
    end
  end

  // NMI acknowledge wins over INTA
  always_comb begin
    if (nmia_i) begin
      m_dat_o = NMI_VECTOR;
    end else if (inta_i) begin
      m_dat_o = IRQ_BASE + kotku_pkg::data_t'(iid_i);
    end else begin
      m_dat_o = bus_dat;
    end
  end

endmodule

`default_nettype wire

// File: simple_pic.sv
/*
 * Simple interrupt controller
 * Latches rising edges on the interrupt lines, reports the
 * lowest numbered pending line and clears it on each new INTA
 */
`timescale 1ns/1ps
`default_nettype none

module simple_pic #(
  parameter int  NUM_IRQ = 8,
  localparam int IID_W   = kotku_pkg::iid_width(NUM_IRQ)
) (
  input  wire               clk,
  input  wire               rst_lck,
  input  wire [NUM_IRQ-1:0] intv_i,
  input  wire               inta_i,
  output logic              intr_o,
  output logic [IID_W-1:0]  iid_o
);

  logic [NUM_IRQ-1:0] intv_q;   // Previous sample of the lines
  logic               inta_q;
  logic [NUM_IRQ-1:0] pending;
  logic [NUM_IRQ-1:0] pending_nxt;

  // Fixed priority, line 0 highest
  always_comb begin
    iid_o = '0;
    for (int i = NUM_IRQ - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = IID_W'(i);
      end
    end
  end

  always_comb begin
    pending_nxt = pending;
    if (inta_i && !inta_q) begin
      pending_nxt[iid_o] = 1'b0;  // Served line drops
    end
    pending_nxt = pending_nxt | (intv_i & ~intv_q);  // New edges win
  end

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      intv_q  <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
    end else begin
      intv_q  <= intv_i;
      inta_q  <= inta_i;
      pending <= pending_nxt;
    end
  end

  assign intr_o = |pending;

endmodule

`default_nettype wire

// File: kotku_bus_core.sv
/*
 * Kotku CPU bus core
 * Connects the memory and I/O decoders, the bus merge and the
 * interrupt controller between the 8086 master and seven slave ports
 */
`timescale 1ns/1ps
`default_nettype none

module kotku_bus_core #(
  parameter kotku_pkg::data_t NMI_VECTOR = 16'd2,
  parameter kotku_pkg::data_t IRQ_BASE   = 16'd8,
  parameter int               NUM_IRQ    = 8
) (
  input  wire                              clk,
  input  wire                              rst_lck,

  // Master port
  input  wire kotku_pkg::wb_req_t          m_req_i,
  output logic                             m_ack_o,
  output kotku_pkg::data_t                 m_dat_o,

  // Slave ports
  output kotku_pkg::wb_req_t               s_req_o,
  output logic [kotku_pkg::NUM_SLAVES-1:0] s_cyc_o,
  input  wire kotku_pkg::wb_rsp_t          s_rsp_i [kotku_pkg::NUM_SLAVES],

  // Interrupts
  input  wire [NUM_IRQ-1:0]                intv_i,
  input  wire                              inta_i,
  input  wire                              nmia_i,
  output logic                             intr_o
);

  localparam int IID_W = kotku_pkg::iid_width(NUM_IRQ);

  kotku_pkg::slave_e mem_slave;
  kotku_pkg::slave_e io_slave;
  logic [IID_W-1:0]  iid;

  mem_decoder mem_decoder_inst (
    .adr_i   (m_req_i.adr),
    .slave_o (mem_slave)
  );

  io_decoder io_decoder_inst (
    .adr_i   (m_req_i.adr),
    .slave_o (io_slave)
  );

  cpu_bus_merge #(
    .NMI_VECTOR (NMI_VECTOR),
    .IRQ_BASE   (IRQ_BASE),
    .NUM_IRQ    (NUM_IRQ)
  ) cpu_bus_merge_inst (
    .m_req_i     (m_req_i),
    .m_ack_o     (m_ack_o),
    .m_dat_o     (m_dat_o),
    .mem_slave_i (mem_slave),
    .io_slave_i  (io_slave),
    .s_req_o     (s_req_o),
    .s_cyc_o     (s_cyc_o),
    .s_rsp_i     (s_rsp_i),
    .iid_i       (iid),
    .inta_i      (inta_i),
    .nmia_i      (nmia_i)
  );

  simple_pic #(
    .NUM_IRQ (NUM_IRQ)
  ) simple_pic_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .intv_i  (intv_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

endmodule

`default_nettype wire

// File: kotku_bus_core_assertions.sv
/*
 * Bus core protocol assertions
 * At most one slave port selected, master ack only inside a cycle,
 * and no interrupt request in the cycle after reset
 */
`timescale 1ns/1ps
`default_nettype none

module kotku_bus_core_assertions (
  input wire                             clk,
  input wire                             rst_lck,
  input wire kotku_pkg::wb_req_t         m_req_i,
  input wire                             m_ack_o,
  input wire [kotku_pkg::NUM_SLAVES-1:0] s_cyc_o,
  input wire                             intr_o
);

  cyc_onehot: assert property (@(posedge clk) disable iff (!rst_lck)
    $onehot0(s_cyc_o))
    else $error("s_cyc_o has more than one bit set: %b", s_cyc_o);

  // Covers the default ack of unmapped I/O too
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_lck)
    m_ack_o |-> (m_req_i.cyc && m_req_i.stb))
    else $error("m_ack_o high without cyc and stb from the master");

  intr_after_reset: assert property (@(posedge clk) !rst_lck |=> !intr_o)
    else $error("intr_o high in the cycle after reset");

endmodule

bind kotku_bus_core kotku_bus_core_assertions kotku_bus_core_assertions_inst (
  .clk     (clk),
  .rst_lck (rst_lck),
  .m_req_i (m_req_i),
  .m_ack_o (m_ack_o),
  .s_cyc_o (s_cyc_o),
  .intr_o  (intr_o)
);

`default_nettype wire

// File: tb_kotku_bus_core.sv
/*
 * Testbench for the Kotku CPU bus core
 * Models the seven slave ports with LFSR driven ack delays and runs a
 * table of bus and interrupt acknowledge entries against the core
 */
`timescale 1ns/1ps
`default_nettype none

module tb_kotku_bus_core;

  localparam kotku_pkg::data_t NMI_VECTOR = 16'h0002;
  localparam kotku_pkg::data_t IRQ_BASE   = 16'h0020;
  localparam int               NUM_IRQ    = 8;
  localparam int               NSLV       = kotku_pkg::NUM_SLAVES;
  localparam int               TIMEOUT    = 20;  // Cycles per wait

  typedef enum logic [1:0] {E_BUS, E_INTA, E_NMIA} kind_e;

  typedef struct packed {
    kind_e              kind;
    logic               tga;
    logic [19:0]        addr;       // Byte address
    logic               we;
    kotku_pkg::data_t   wdat;
    logic [1:0]         sel;
    kotku_pkg::slave_e  exp_slave;
    logic [NUM_IRQ-1:0] intv;
    kotku_pkg::data_t   exp_vec;
    logic               intr_after;
  } entry_t;

  logic               clk;
  logic               rst_lck;
  kotku_pkg::wb_req_t m_req;
  logic               m_ack;
  kotku_pkg::data_t   m_dat;
  kotku_pkg::wb_req_t s_req;
  logic [NSLV-1:0]    s_cyc;
  kotku_pkg::wb_rsp_t s_rsp [NSLV];
  logic [NUM_IRQ-1:0] intv;
  logic               inta;
  logic               nmia;
  logic               intr;

  // Slave model state
  logic [1:0]         wait_cnt [NSLV];
  logic [1:0]         delay [NSLV];
  int                 cyc_cnt [NSLV];     // Cycles with cyc high
  int                 cnt_before [NSLV];
  kotku_pkg::data_t   wr_dat [NSLV];
  logic [1:0]         wr_sel [NSLV];
  logic [31:0]        lfsr = 32'h37ca_a752;

  entry_t             tests [$];
  int                 check_errors = 0;
  int                 tests_failed = 0;

  kotku_bus_core #(
    .NMI_VECTOR (NMI_VECTOR),
    .IRQ_BASE   (IRQ_BASE),
    .NUM_IRQ    (NUM_IRQ)
  ) kotku_bus_core_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .m_req_i (m_req),
    .m_ack_o (m_ack),
    .m_dat_o (m_dat),
    .s_req_o (s_req),
    .s_cyc_o (s_cyc),
    .s_rsp_i (s_rsp),
    .intv_i  (intv),
    .inta_i  (inta),
    .nmia_i  (nmia),
    .intr_o  (intr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Slave id above the CPU address low byte
  function automatic kotku_pkg::data_t read_pattern(input int id, input kotku_pkg::addr_t adr);
    return {5'b10100, 3'(id), adr[7:1], 1'b0};
  endfunction

  function automatic logic [19:0] byte_addr(input kotku_pkg::addr_t base, input logic [19:0] off);
    return {base, 1'b0} + off;
  endfunction

  always_comb begin
    for (int i = 0; i < NSLV; i++) begin
      s_rsp[i].ack = s_cyc[i] && s_req.stb && (wait_cnt[i] == delay[i]);
      s_rsp[i].dat = read_pattern(i, s_req.adr);
    end
  end

  always @(posedge clk) begin
    for (int i = 0; i < NSLV; i++) begin
      if (!rst_lck) begin
        wait_cnt[i] <= 2'd0;
        delay[i]    <= 2'd0;
      end else if (s_rsp[i].ack) begin
        wait_cnt[i] <= 2'd0;
        if (s_req.we) begin
          wr_dat[i] <= s_req.dat;
          wr_sel[i] <= s_req.sel;
        end
        lfsr = lfsr_next(lfsr);  // One step per delay bit
        delay[i][0] <= lfsr[0];
        lfsr = lfsr_next(lfsr);
        delay[i][1] <= lfsr[0];
      end else if (s_cyc[i] && s_req.stb) begin
        wait_cnt[i] <= wait_cnt[i] + 2'd1;
      end
      if (s_cyc[i]) begin
        cyc_cnt[i] <= cyc_cnt[i] + 1;
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      check_errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Check failed at %0t ns: %s", $time, what);
      check_errors++;
    end
  endtask

  task automatic add_bus(input logic tga, input logic [19:0] addr, input logic we,
                         input kotku_pkg::data_t wdat, input logic [1:0] sel,
                         input kotku_pkg::slave_e exp);
    entry_t e;
    e = '0;
    e.kind = E_BUS;
    e.tga = tga;
    e.addr = addr;
    e.we = we;
    e.wdat = wdat;
    e.sel = sel;
    e.exp_slave = exp;
    tests.push_back(e);
  endtask

  task automatic add_read(input logic tga, input logic [19:0] addr,
                          input kotku_pkg::slave_e exp);
    add_bus(tga, addr, 1'b0, 16'h0000, 2'b11, exp);
  endtask

  task automatic add_ack(input kind_e kind, input logic [NUM_IRQ-1:0] lines,
                         input kotku_pkg::data_t vec, input logic intr_after);
    entry_t e;
    e = '0;
    e.kind = kind;
    e.intv = lines;
    e.exp_vec = vec;
    e.intr_after = intr_after;
    tests.push_back(e);
  endtask

  task automatic build_table();
    add_read(1'b0, byte_addr(kotku_pkg::MEM_ROM_BASE, 20'h001f0), kotku_pkg::SLV_ROM);
    add_read(1'b0, byte_addr(kotku_pkg::MEM_VGA_BASE, 20'h18010), kotku_pkg::SLV_VGA);
    add_read(1'b0, 20'h12344, kotku_pkg::SLV_RAM);
    add_read(1'b1, byte_addr(kotku_pkg::IO_VGA_BASE, 20'h4), kotku_pkg::SLV_VGA);
    add_read(1'b1, byte_addr(kotku_pkg::IO_UART_BASE, 20'h0), kotku_pkg::SLV_UART);
    add_read(1'b1, byte_addr(kotku_pkg::IO_KEYB_BASE, 20'h4), kotku_pkg::SLV_KEYB);
    add_read(1'b1, byte_addr(kotku_pkg::IO_TIMER_BASE, 20'h2), kotku_pkg::SLV_TIMER);
    add_read(1'b1, byte_addr(kotku_pkg::IO_GPIO_BASE, 20'h2), kotku_pkg::SLV_GPIO);
    add_read(1'b0, 20'h003c4, kotku_pkg::SLV_RAM);  // Port numbers in memory space
    add_read(1'b0, 20'h003f8, kotku_pkg::SLV_RAM);
    add_read(1'b0, 20'h00064, kotku_pkg::SLV_RAM);
    add_read(1'b0, 20'h00042, kotku_pkg::SLV_RAM);
    add_read(1'b0, 20'h0f102, kotku_pkg::SLV_RAM);
    add_bus(1'b1, 20'h003f8, 1'b1, 16'hbeef, 2'b01, kotku_pkg::SLV_UART);
    add_bus(1'b0, 20'ha0100, 1'b1, 16'h1234, 2'b11, kotku_pkg::SLV_VGA);
    add_bus(1'b1, 20'h0f102, 1'b1, 16'h5a5a, 2'b10, kotku_pkg::SLV_GPIO);
    add_bus(1'b0, 20'h40000, 1'b1, 16'hc3c3, 2'b11, kotku_pkg::SLV_RAM);
    add_read(1'b1, 20'h00100, kotku_pkg::SLV_NONE);
    add_read(1'b1, 20'h0f300, kotku_pkg::SLV_NONE);
    add_bus(1'b1, 20'h0f300, 1'b1, 16'hffff, 2'b11, kotku_pkg::SLV_NONE);
    add_ack(E_INTA, 8'h12, IRQ_BASE + 16'd1, 1'b1);  // Lines 4 and 1 together
    add_ack(E_INTA, 8'h00, IRQ_BASE + 16'd4, 1'b0);
    add_ack(E_NMIA, 8'h04, NMI_VECTOR, 1'b0);
  endtask

  task automatic bus_cycle(input entry_t e, output kotku_pkg::data_t rdat,
                           output logic [NSLV-1:0] cyc_seen, output logic acked);
    kotku_pkg::wb_req_t req;
    int waited;
    req = '{cyc: 1'b1, stb: 1'b1, tga: e.tga, we: e.we, sel: e.sel,
            adr: e.addr[19:1], dat: e.wdat};
    waited = 0;
    @(posedge clk);
    m_req <= req;
    @(negedge clk);
    while (!m_ack && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    acked = m_ack;
    rdat = m_dat;
    cyc_seen = s_cyc;
    @(posedge clk);
    m_req <= '0;  // Cycle ends on this edge
  endtask

  task automatic run_bus_entry(input entry_t e);
    kotku_pkg::data_t rdat;
    logic [NSLV-1:0] cyc_seen;
    logic acked;
    int id;
    id = int'(e.exp_slave);
    @(negedge clk);
    cnt_before = cyc_cnt;
    bus_cycle(e, rdat, cyc_seen, acked);
    @(negedge clk);
    expect_true(acked, "no m_ack_o before the timeout");
    if (e.exp_slave == kotku_pkg::SLV_NONE) begin
      compare_value("s_cyc_o", 32'(cyc_seen), 32'h0);
      compare_value("m_dat_o", 32'(rdat), 32'h0);
    end else if (e.we) begin
      compare_value("s_cyc_o", 32'(cyc_seen), 32'h1 << id);
      compare_value("written dat", 32'(wr_dat[id]), 32'(e.wdat));
      compare_value("written sel", 32'(wr_sel[id]), 32'(e.sel));
    end else begin
      compare_value("s_cyc_o", 32'(cyc_seen), 32'h1 << id);
      compare_value("m_dat_o", 32'(rdat), 32'(read_pattern(id, e.addr[19:1])));
    end
    for (int i = 0; i < NSLV; i++) begin
      if (i != id) begin
        compare_value($sformatf("s_cyc_o[%0d] cycles", i), cyc_cnt[i], cnt_before[i]);
      end
    end
  endtask

  task automatic pulse_lines(input logic [NUM_IRQ-1:0] lines);
    int waited;
    waited = 0;
    @(posedge clk);
    intv <= lines;
    @(negedge clk);
    while (!intr && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    expect_true(intr, "intr_o stayed low after the interrupt lines rose");
    @(posedge clk);
    intv <= '0;
  endtask

  task automatic run_ack_entry(input entry_t e);
    if (|e.intv) begin
      pulse_lines(e.intv);
    end
    @(posedge clk);
    inta <= 1'b1;
    nmia <= (e.kind == E_NMIA);
    @(negedge clk);
    compare_value("m_dat_o", 32'(m_dat), 32'(e.exp_vec));
    @(posedge clk);
    inta <= 1'b0;
    nmia <= 1'b0;
    @(negedge clk);
    compare_value("intr_o", 32'(intr), 32'(e.intr_after));
  endtask

  task automatic check_idle();
    compare_value("s_cyc_o", 32'(s_cyc), 32'h0);
    compare_value("m_ack_o", 32'(m_ack), 32'h0);
    compare_value("intr_o", 32'(intr), 32'h0);
  endtask

  task automatic report_test(input int num, input string label, input int errs_before);
    if (check_errors == errs_before) begin
      $display("Test %0d %s: ok", num, label);
    end else begin
      $display("Test %0d %s: failed", num, label);
      tests_failed++;
    end
  endtask

  initial begin
    entry_t e;
    int errs_before;
    rst_lck <= 1'b0;
    m_req <= '0;
    intv <= '0;
    inta <= 1'b0;
    nmia <= 1'b0;
    build_table();
    repeat (2) @(posedge clk);
    rst_lck <= 1'b1;
    @(negedge clk);
    errs_before = check_errors;
    check_idle();
    report_test(0, "idle after reset", errs_before);

    for (int t = 0; t < tests.size(); t++) begin
      e = tests[t];
      errs_before = check_errors;
      if (e.kind == E_BUS) begin
        run_bus_entry(e);
        report_test(t + 1, $sformatf("%s %h %s", e.tga ? "io" : "mem", e.addr,
                                      e.exp_slave.name()), errs_before);
      end else begin
        run_ack_entry(e);
        report_test(t + 1, e.kind.name(), errs_before);
      end
    end

    // A pending line must not survive reset
    errs_before = check_errors;
    pulse_lines(8'h40);
    @(posedge clk);
    rst_lck <= 1'b0;
    repeat (2) @(posedge clk);
    rst_lck <= 1'b1;
    @(negedge clk);
    check_idle();
    report_test(tests.size() + 1, "reset clears pending", errs_before);

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests.size() + 2, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
kotku_pkg.sv
mem_decoder.sv
io_decoder.sv
cpu_bus_merge.sv
simple_pic.sv
kotku_bus_core.sv
kotku_bus_core_assertions.sv
tb_kotku_bus_core.sv

// File: run.sh
#!/bin/sh
# Build the bus core testbench with Verilator and run it.
# The run fails when the log holds the fail message or the simulator stops early.

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_kotku_bus_core -o tb_kotku_bus_core > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_kotku_bus_core > sim.log 2>&1 && sim_ok=1 || sim_ok=0
cat sim.log

grep -q "=== FAIL ===" sim.log && exit 1
[ "$sim_ok" -eq 1 ] && grep -q "=== PASS ===" sim.log || exit 1
exit 0
